//--- logic/sbox_defines.svh
`ifndef SBOX_DEFINES_SVH
`define SBOX_DEFINES_SVH

// Queue depths, one entry per operand or result
`define SBOX_REQ_DEPTH 4
`define SBOX_RES_DEPTH 4

// Occupancy count width, enough for depths up to 7
`define SBOX_CNT_W 3

// Register stages in the inversion pipeline
`define SBOX_PIPE_DEPTH 2

// APB register map
`define SBOX_ADDR_W      4
`define SBOX_ADDR_IN     4'h0
`define SBOX_ADDR_OUT    4'h4
`define SBOX_ADDR_STATUS 4'h8

`endif

//--- logic/gf64_pkg.sv
`default_nettype none

package gf64_pkg;

  // Queue payloads
  typedef struct packed {
    logic [3:0] tag;
    logic [5:0] operand;
  } sbox_req_t;

  typedef struct packed {
    logic [3:0] tag;
    logic [5:0] inverse;
  } sbox_res_t;

  // GF(2^3) element in normal basis
  typedef logic [2:0] gf8_t;

  function automatic gf8_t gf8_mul(input gf8_t a, input gf8_t b);
    logic [2:0] t;
    gf8_t c;
    t[0] = (a[0] & b[1]) ^ (a[1] & b[0]);
    t[1] = (a[1] & b[2]) ^ (a[2] & b[1]);
    t[2] = (a[0] & b[2]) ^ (a[2] & b[0]);
    c[0] = (a[2] & b[2]) ^ t[0] ^ t[1];
    c[1] = (a[0] & b[0]) ^ t[1] ^ t[2];
    c[2] = (a[1] & b[1]) ^ t[2] ^ t[0];
    return c;
  endfunction

  // Squaring in a normal basis is a cyclic shift
  function automatic gf8_t gf8_sq(input gf8_t a);
    return {a[1], a[0], a[2]};
  endfunction

  // a^6 equals a^-1 for nonzero a and maps 0 to 0
  function automatic gf8_t gf8_pow6(input gf8_t a);
    gf8_t b;
    b[0] = a[0] ^ (~a[1] & a[2]);
    b[1] = a[1] ^ (~a[2] & a[0]);
    b[2] = a[2] ^ (~a[0] & a[1]);
    return b;
  endfunction

  // Polynomial basis of GF(2^6) into GF((2^3)^2), high half in bits 5:3
  function automatic logic [5:0] to_tower(input logic [5:0] a);
    logic [5:0] b;
    b[0] = a[0] ^ a[1];
    b[1] = a[0] ^ a[3];
    b[2] = a[0] ^ a[2] ^ a[4] ^ a[5];
    b[3] = a[0] ^ a[4] ^ a[5];
    b[4] = a[0] ^ a[1] ^ a[2] ^ a[5];
    b[5] = a[0] ^ a[5];
    return b;
  endfunction

  function automatic logic [5:0] from_tower(input logic [5:0] a);
    logic [5:0] b;
    b[0] = a[0] ^ a[2] ^ a[3] ^ a[4] ^ a[5];
    b[1] = a[2] ^ a[3] ^ a[4] ^ a[5];
    b[2] = a[2] ^ a[3];
    b[3] = a[0] ^ a[1] ^ a[2] ^ a[3] ^ a[4] ^ a[5];
    b[4] = a[3] ^ a[5];
    b[5] = a[0] ^ a[2] ^ a[3] ^ a[4];
    return b;
  endfunction

endpackage

`default_nettype wire

//--- logic/sbox_queue.sv
`default_nettype none

module sbox_queue #(
  parameter int  DEPTH  = 4,
  parameter type item_t = logic [7:0]
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  item_t                        push_item,
  output logic                         full,
  input  logic                         pop,
  output item_t                        head_item,
  output logic                         valid,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  item_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign full      = (count == CW'(DEPTH));
  assign valid     = (count != '0);
  assign head_item = mem[rd_ptr]; // Show-ahead head
  assign do_push   = push && !full;
  assign do_pop    = pop && valid;

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_item;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the count unchanged
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/apb_sbox_regs.sv
`default_nettype none
`include "sbox_defines.svh"

module apb_sbox_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`SBOX_ADDR_W-1:0]  paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  logic                     req_full,
  input  logic [`SBOX_CNT_W-1:0]   req_count,
  output logic                     req_push,
  output gf64_pkg::sbox_req_t      req_item,
  input  gf64_pkg::sbox_res_t      res_item,
  input  logic                     res_valid,
  input  logic [`SBOX_CNT_W-1:0]   res_count,
  output logic                     res_pop
);

  logic       access;
  logic       wr_in;
  logic       rd_out;
  logic       rd_stat;
  logic       bad_addr;
  logic [3:0] tag;

  assign access   = psel && penable; // Access phase, every transfer completes here
  assign wr_in    = access && pwrite && (paddr == `SBOX_ADDR_IN);
  assign rd_out   = access && !pwrite && (paddr == `SBOX_ADDR_OUT);
  assign rd_stat  = access && !pwrite && (paddr == `SBOX_ADDR_STATUS);
  assign bad_addr = access && !(wr_in || rd_out || rd_stat);

  assign pready   = 1'b1;
  assign pslverr  = (wr_in && req_full) || (rd_out && !res_valid) || bad_addr;

  assign req_push = wr_in && !req_full;
  assign res_pop  = rd_out && res_valid;

  always_comb begin
    req_item.tag     = tag;
    req_item.operand = pwdata[5:0];
  end

  always_comb begin
    prdata = '0;
    if (rd_out && res_valid) begin
      prdata[9:6] = res_item.tag;
      prdata[5:0] = res_item.inverse;
    end else if (rd_stat) begin
      prdata[`SBOX_CNT_W-1:0]    = req_count;
      prdata[8 +: `SBOX_CNT_W]   = res_count;
    end
  end

  // Sequence tag only advances on an accepted write
  always_ff @(posedge clk) begin
    if (rst)
      tag <= '0;
    else if (req_push)
      tag <= tag + 1'b1; // Wraps at 16
  end

endmodule

`default_nettype wire

//--- logic/gf64_inverse_pipe.sv
`default_nettype none
`include "sbox_defines.svh"

module gf64_inverse_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  gf64_pkg::sbox_req_t  in_item,
  input  logic                 in_valid,
  output logic                 in_pop,
  output gf64_pkg::sbox_res_t  out_item,
  output logic                 out_push,
  input  logic                 out_full
);

  import gf64_pkg::*;

  logic [`SBOX_PIPE_DEPTH-1:0] vld;
  logic adv1;
  logic adv2;
  sbox_req_t s1; // Operand field holds the tower form
  sbox_res_t s2;
  gf8_t lo;
  gf8_t hi;
  gf8_t sum;
  gf8_t d;
  gf8_t d_inv;
  logic [5:0] inv_tower;

  // A stage moves when the result queue takes its item or the stage ahead is empty
  assign adv2     = !vld[1] || !out_full;
  assign adv1     = !vld[0] || adv2;
  assign in_pop   = in_valid && adv1;
  assign out_push = vld[1];
  assign out_item = s2;

  // Inversion in GF((2^3)^2)
  always_comb begin
    lo        = s1.operand[2:0];
    hi        = s1.operand[5:3];
    sum       = lo ^ hi;
    d         = gf8_sq(hi) ^ gf8_mul(lo, sum);
    d_inv     = gf8_pow6(d);
    inv_tower = {gf8_mul(lo, d_inv), gf8_mul(hi, d_inv)};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else begin
      if (adv1)
        vld[0] <= in_valid;
      if (adv2)
        vld[1] <= vld[0];
    end
  end

  always_ff @(posedge clk) begin
    if (adv1) begin
      s1.tag     <= in_item.tag;
      s1.operand <= to_tower(in_item.operand);
    end
    if (adv2) begin
      s2.tag     <= s1.tag;
      s2.inverse <= from_tower(inv_tower);
    end
  end

endmodule

`default_nettype wire

//--- logic/apb_sbox_engine.sv
`default_nettype none
`include "sbox_defines.svh"

module apb_sbox_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`SBOX_ADDR_W-1:0]  paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr
);

  import gf64_pkg::*;

  sbox_req_t req_item;
  sbox_req_t req_head;
  sbox_res_t res_item;
  sbox_res_t res_head;
  logic req_push;
  logic req_full;
  logic req_valid;
  logic req_pop;
  logic res_push;
  logic res_full;
  logic res_valid;
  logic res_pop;
  logic [`SBOX_CNT_W-1:0] req_count;
  logic [`SBOX_CNT_W-1:0] res_count;

  apb_sbox_regs regs (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .req_full  (req_full),
    .req_count (req_count),
    .req_push  (req_push),
    .req_item  (req_item),
    .res_item  (res_head),
    .res_valid (res_valid),
    .res_count (res_count),
    .res_pop   (res_pop)
  );

  sbox_queue #(.DEPTH(`SBOX_REQ_DEPTH), .item_t(sbox_req_t)) req_q (
    .clk       (clk),
    .rst       (rst),
    .push      (req_push),
    .push_item (req_item),
    .full      (req_full),
    .pop       (req_pop),
    .head_item (req_head),
    .valid     (req_valid),
    .count     (req_count)
  );

  gf64_inverse_pipe pipe (
    .clk      (clk),
    .rst      (rst),
    .in_item  (req_head),
    .in_valid (req_valid),
    .in_pop   (req_pop),
    .out_item (res_item),
    .out_push (res_push),
    .out_full (res_full)
  );

  sbox_queue #(.DEPTH(`SBOX_RES_DEPTH), .item_t(sbox_res_t)) res_q (
    .clk       (clk),
    .rst       (rst),
    .push      (res_push),
    .push_item (res_item),
    .full      (res_full),
    .pop       (res_pop),
    .head_item (res_head),
    .valid     (res_valid),
    .count     (res_count)
  );

endmodule

`default_nettype wire

//--- verification/apb_sbox_engine_tb.sv
`default_nettype none
`include "sbox_defines.svh"

module apb_sbox_engine_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VEC    = 35;
  localparam int MAX_CYCLES = 40 * (2 * NUM_VEC + 16) + 400;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [7:0] vec_mem [0:2*NUM_VEC-1]; // Even entries operand, odd entries inverse
  int         order [NUM_VEC];
  logic [7:0] lfsr;
  logic [3:0] next_tag;
  logic [9:0] exp_q [$];               // Expected {tag, inverse} in read order
  int         cycles;

  apb_sbox_engine uut (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      fail_now("Run did not finish within the cycle limit");
  end

  // Taps 8,6,5,4 for a maximal length sequence
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[7];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      fail_now($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      if (exp)
        fail_now($sformatf("Expected pslverr on %s but the transfer succeeded", what));
      else
        fail_now($sformatf("Unexpected pslverr on %s", what));
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #10 err = pslverr; // Sampled halfway through the access phase
    check_val("pready", pready, 1'b1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #10;
    data = prdata;
    err  = pslverr;
    check_val("pready", pready, 1'b1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_status(input int res_min, input int req_min);
    logic [31:0] rd;
    logic        err;
    do begin
      apb_read(`SBOX_ADDR_STATUS, rd, err);
      check_err("read of STATUS", err, 1'b0);
    end while (rd[10:8] < res_min || rd[2:0] < req_min);
  endtask

  task automatic push_write(input logic [5:0] op, input logic [5:0] inv, input logic refuse);
    logic err;
    apb_write(`SBOX_ADDR_IN, {26'd0, op}, err);
    check_err("write of DATA_IN", err, refuse);
    if (!err) begin
      exp_q.push_back({next_tag, inv});
      next_tag = next_tag + 1'b1;
    end
  endtask

  task automatic pop_read(output logic [5:0] got);
    logic [31:0] rd;
    logic        err;
    logic [9:0]  exp;
    wait_status(1, 0);
    apb_read(`SBOX_ADDR_OUT, rd, err);
    check_err("read of DATA_OUT", err, 1'b0);
    exp = exp_q.pop_front();
    check_val("prdata.tag", rd[9:6], exp[9:6]);
    check_val("prdata.inverse", rd[5:0], exp[5:0]);
    got = rd[5:0];
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [5:0]  got [NUM_VEC];
    logic [5:0]  tmp;
    int          j;
    int          t;

    clk      = 1'b0;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    cycles   = 0;
    lfsr     = 8'd81;
    next_tag = '0;

    $readmemh("verification/sbox_tests.txt", vec_mem);
    if ($isunknown(vec_mem[2*NUM_VEC-1]))
      fail_now("Test vector file is missing or too short");

    // Shuffle the walk order
    for (int i = 0; i < NUM_VEC; i++)
      order[i] = i;
    for (int i = NUM_VEC - 1; i > 0; i--) begin
      rand_bits(6, j);
      j = j % (i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end

    repeat (2) @(posedge clk);
    @(negedge clk) rst = 1'b0;

    apb_read(`SBOX_ADDR_STATUS, rd, err);
    check_err("read of STATUS after reset", err, 1'b0);
    check_val("prdata", rd, 32'h0);
    apb_read(`SBOX_ADDR_OUT, rd, err);
    check_err("read of an empty DATA_OUT", err, 1'b1);
    check_val("prdata", rd, 32'h0);

    for (int i = 0; i < NUM_VEC; i++) begin
      push_write(vec_mem[2*order[i]][5:0], vec_mem[2*order[i]+1][5:0], 1'b0);
      pop_read(got[i]);
    end

    // The inverse of the inverse is the operand
    for (int i = 0; i < NUM_VEC; i++) begin
      push_write(got[i], vec_mem[2*order[i]][5:0], 1'b0);
      pop_read(tmp);
    end

    for (int i = 0; i < 4; i++)
      push_write(vec_mem[2*order[i]][5:0], vec_mem[2*order[i]+1][5:0], 1'b0);
    for (int i = 0; i < 4; i++)
      pop_read(tmp);

    for (int i = 0; i < 10; i++)
      push_write(vec_mem[2*order[i+4]][5:0], vec_mem[2*order[i+4]+1][5:0], 1'b0);
    wait_status(`SBOX_RES_DEPTH, `SBOX_REQ_DEPTH);
    push_write(vec_mem[0][5:0], vec_mem[1][5:0], 1'b1);
    for (int i = 0; i < 10; i++)
      pop_read(tmp);
    push_write(vec_mem[2][5:0], vec_mem[3][5:0], 1'b0);
    pop_read(tmp);

    // Every accepted operand has been read back, so both queues are empty
    apb_read(`SBOX_ADDR_STATUS, rd, err);
    check_err("final read of STATUS", err, 1'b0);
    check_val("prdata", rd, 32'h0);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/sbox_tests.txt
// operand inverse, hex, GF(2^6) modulo x^6+x^4+x^3+x+1
// zero maps to zero
00 00
01 01
02 2D
04 3B
08 30
10 18
20 0C
1B 06
36 03
37 2C
35 16
31 0B
39 28
29 14
09 0A
12 05
24 2F
13 3A
26 1D
17 23
2E 3C
07 1E
0E 0F
1C 2A
38 15
2B 27
0D 3E
1A 1F
34 22
33 11
3D 25
21 3F
19 32
3F 21
2D 02

//--- list.f
+incdir+logic
logic/gf64_pkg.sv
logic/sbox_queue.sv
logic/apb_sbox_regs.sv
logic/gf64_inverse_pipe.sv
logic/apb_sbox_engine.sv
verification/apb_sbox_engine_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module apb_sbox_engine_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qF '** PASS **' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
